// ==== Bender.yml ====
package:
  name: chroni_text

sources:
  - verilog/chroni_pkg.sv
  - verilog/chroni_regs.sv
  - verilog/vram.sv
  - verilog/glyph_fetch.sv
  - verilog/attr_fetch.sv
  - verilog/pixel_shifter.sv
  - verilog/chroni_text.sv
  - target: test
    files:
      - tb/chroni_text_tb.sv

// ==== chroni_text.f ====
verilog/chroni_pkg.sv
verilog/chroni_regs.sv
verilog/vram.sv
verilog/glyph_fetch.sv
verilog/attr_fetch.sv
verilog/pixel_shifter.sv
verilog/chroni_text.sv
tb/chroni_text_tb.sv

// ==== tb/chroni_text_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroni_text_tb;
   import chroni_pkg::*;

   localparam int ACK_LIMIT  = 16;     // cycles per bus transfer
   localparam int POLL_LIMIT = 1000;   // busy reads per line

   logic        sys_clk;
   logic        rst;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   reg_addr_t   wb_adr;
   byte_t       wb_dat_w;
   byte_t       wb_dat_r;
   logic        wb_ack;
   color_t      pixel;
   logic        pixel_valid;
   logic        pixel_ready;

   color_t      exp_q[$];   // pixels still to come in transfer order
   color_t      exp_pix;
   logic [31:0] rnd;
   string       cur_test;
   string       op;
   string       name;
   logic [8*128-1:0] line_buf;
   logic [31:0] f_reg;
   logic [31:0] f_val;
   logic [31:0] f_cnt;
   logic [31:0] f_step;
   byte_t       rdat;
   int          fd;
   int          c;
   int          n;
   int          errs;
   int          test_start_errs;
   int          tests_ok;
   int          tests_bad;
   int          pix_index;
   logic        have_test;
   logic        timed_out;
   logic        line_active;   // a start was written and the line has not drained yet

   chroni_text UUT (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .pixel       (pixel),
      .pixel_valid (pixel_valid),
      .pixel_ready (pixel_ready)
   );

   always #2 sys_clk = ~sys_clk;   // 4 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // one classic cycle held until ack and then released
   task automatic bus_access(input logic we, input reg_addr_t adr, input byte_t wdat,
                             output byte_t data);
      int cnt;
      cnt      = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      @(negedge sys_clk);
      while (!wb_ack && cnt < ACK_LIMIT) begin
         @(negedge sys_clk);
         cnt++;
      end
      if (!wb_ack) begin
         $display("timeout: register %0d never acked in test %s", adr, cur_test);
         errs++;
         timed_out = 1'b1;
      end
      data   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge sys_clk);
      assert (wb_ack === 1'b0) else begin
         $display("ack for register %0d stayed high in test %s", adr, cur_test);
         errs++;
      end
   endtask

   task automatic bus_read_check(input reg_addr_t adr, input byte_t expect_val);
      byte_t got;
      bus_access(1'b0, adr, 8'h00, got);
      assert (got === expect_val) else begin
         $display("[FAIL] %s: reg %0d expected %h actual %h", cur_test, adr, expect_val, got);
         errs++;
      end
   endtask

   // last column sits in the shifter and both fetchers are idle while busy is still set
   task automatic wait_last_column();
      int cnt;
      cnt = 0;
      while (exp_q.size() > 7 && cnt < POLL_LIMIT) begin
         @(negedge sys_clk);
         cnt++;
      end
      if (exp_q.size() > 7) begin
         $display("timeout: last column never reached the shifter in test %s", cur_test);
         errs++;
         timed_out = 1'b1;
      end
   endtask

   // a column word holds 8 colour indices with the leftmost pixel in the top nibble
   task automatic queue_pixels(input int cols, input logic [31:0] word);
      for (int i = 0; i < cols; i++) begin
         for (int k = 7; k >= 0; k--)
            exp_q.push_back(word[4*k +: 4]);
      end
   endtask

   task automatic finish_test();
      if (errs == test_start_errs) begin
         tests_ok++;
         $display("test %s: ok", cur_test);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", cur_test, errs - test_start_errs);
      end
   endtask

   // ready changes on the falling edge and a pixel counts when valid and ready
   // are both set for the coming rising edge
   always @(negedge sys_clk) begin
      rnd         = xorshift(rnd);
      pixel_ready = (rnd[1:0] != 2'b00);   // low about one cycle in four
      if (!rst && pixel_valid && pixel_ready) begin
         assert (exp_q.size() > 0) else begin
            $display("pixel %0d arrived with none expected in test %s", pix_index, cur_test);
            errs++;
         end
         if (exp_q.size() > 0) begin
            exp_pix = exp_q.pop_front();
            assert (pixel === exp_pix) else begin
               $display("[FAIL] %s: pixel %0d expected %h actual %h",
                        cur_test, pix_index, exp_pix, pixel);
               errs++;
            end
         end
         pix_index++;
      end
   end

   initial begin
      sys_clk         = 1'b0;
      rst             = 1'b1;
      wb_cyc          = 1'b0;
      wb_stb          = 1'b0;
      wb_we           = 1'b0;
      wb_adr          = '0;
      wb_dat_w        = '0;
      pixel_ready     = 1'b0;
      rnd             = 32'd16;
      cur_test        = "none";
      errs            = 0;
      test_start_errs = 0;
      tests_ok        = 0;
      tests_bad       = 0;
      pix_index       = 0;
      have_test       = 1'b0;
      timed_out       = 1'b0;
      line_active     = 1'b0;
      repeat (8) @(negedge sys_clk);
      rst = 1'b0;
      fd = $fopen("tb/chroni_text_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open tb/chroni_text_trace.txt");
         errs++;
      end else begin
         while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
            if (op[0] == "#") begin
               c = $fgets(line_buf, fd);
            end else begin
               case (op)
                  "t": begin
                     c = $fscanf(fd, "%s", name);
                     if (have_test)
                        finish_test();
                     cur_test        = name;
                     test_start_errs = errs;
                     have_test       = 1'b1;
                     pix_index       = 0;
                  end
                  "q": assert (pixel_valid === 1'b0) else begin
                     $display("pixel_valid high while idle in test %s", cur_test);
                     errs++;
                  end
                  "w": begin
                     c = $fscanf(fd, "%h %h", f_reg, f_val);
                     bus_access(1'b1, reg_addr_t'(f_reg), byte_t'(f_val), rdat);
                  end
                  "s": begin
                     c = $fscanf(fd, "%h %h %d %h", f_reg, f_val, f_cnt, f_step);
                     for (int i = 0; i < f_cnt; i++)
                        bus_access(1'b1, reg_addr_t'(f_reg), byte_t'(f_val + i * f_step), rdat);
                  end
                  "r": begin
                     c = $fscanf(fd, "%h %h", f_reg, f_val);
                     bus_read_check(reg_addr_t'(f_reg), byte_t'(f_val));
                  end
                  "g": begin
                     if (line_active)
                        wait_last_column();
                     bus_access(1'b1, REG_CTRL, 8'h01, rdat);
                     line_active = 1'b1;
                  end
                  "p": begin
                     c = $fscanf(fd, "%d %h", f_cnt, f_val);
                     queue_pixels(f_cnt, f_val);
                  end
                  "d": begin
                     rdat = 8'h01;
                     n    = 0;
                     while (rdat[0] && !timed_out && n < POLL_LIMIT) begin
                        bus_access(1'b0, REG_CTRL, 8'h00, rdat);
                        n++;
                     end
                     if (rdat[0]) begin
                        $display("timeout: render still busy in test %s", cur_test);
                        errs++;
                        timed_out = 1'b1;
                     end
                     line_active = 1'b0;
                     assert (exp_q.size() == 0) else begin
                        $display("%0d pixels never arrived in test %s", exp_q.size(), cur_test);
                        errs++;
                     end
                  end
                  default: begin
                     $display("unknown trace operation %s", op);
                     errs++;
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      if (have_test)
         finish_test();
      $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errs);
      if (errs == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/chroni_text_trace.txt ====
# t name | q idle check | w reg data | r reg expect | s reg data count step | g start | d wait idle
# p columns word: 8 colour indices per column, leftmost pixel first, repeated for the columns
t reset
q
r 9 00
r 3 00
r 4 00
r 5 00
r 7 00
t regs
w 3 f0
w 4 10
w 5 f8
w 6 21
w 7 30
w 8 03
r 3 f0
r 4 10
r 5 f8
r 6 21
r 7 30
r 8 03
t load
w 0 f0
w 1 10
s 2 01 16 00
s 2 02 32 00
r 0 20
r 1 11
w 0 f8
w 1 21
s 2 1e 8 00
s 2 5a 24 00
s 2 c3 16 00
w 0 08
w 1 30
s 2 0f 16 11
t line1
p 8 1e1111e1
p 8 5a5555a5
p 16 aa55a5a5
p 8 33cc3c3c
g
r 9 01
g
d
r 9 00
q
t line2
w 3 f8
w 5 00
w 6 22
w 8 05
p 8 5aa55a55
p 16 aaa5aa55
p 16 333c33cc
g
d

// ==== verilog/attr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module attr_fetch (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   start,
   input  chroni_pkg::vram_addr_t attr_base,
   output chroni_pkg::vram_addr_t rd1_addr,
   input  chroni_pkg::byte_t      rd1_data,
   output chroni_pkg::byte_t      attr_byte,
   output logic                   attr_valid,
   input  logic                   take
);
   import chroni_pkg::*;

   attr_state_t state;
   col_t        col;

   assign rd1_addr   = attr_base + vram_addr_t'(col);   // constant while holding
   assign attr_byte  = rd1_data;
   assign attr_valid = (state == A_HOLD);

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         state <= A_IDLE;
         col   <= '0;
      end else begin
         case (state)
            A_IDLE: if (start) begin
               col   <= '0;
               state <= A_READ;
            end
            A_READ: state <= A_HOLD;
            A_HOLD: if (take) begin
               if (col == col_t'(LINE_COLS - 1)) begin
                  state <= A_IDLE;   // line finished
               end else begin
                  col   <= col + 1'b1;
                  state <= A_READ;
               end
            end
            default: state <= A_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/chroni_pkg.sv ====
`default_nettype none

package chroni_pkg;

   typedef logic [13:0] vram_addr_t;   // 16 KiB video memory
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  color_t;
   typedef logic [5:0]  col_t;
   typedef logic [2:0]  scan_t;
   typedef logic [3:0]  reg_addr_t;

   // text line geometry
   localparam int LINE_COLS   = 40;
   localparam int GLYPH_BYTES = 8;

   // register map
   localparam reg_addr_t REG_ADDR_LO   = 4'd0;
   localparam reg_addr_t REG_ADDR_HI   = 4'd1;
   localparam reg_addr_t REG_DATA      = 4'd2;   // write only
   localparam reg_addr_t REG_TEXT_LO   = 4'd3;
   localparam reg_addr_t REG_TEXT_HI   = 4'd4;
   localparam reg_addr_t REG_ATTR_LO   = 4'd5;
   localparam reg_addr_t REG_ATTR_HI   = 4'd6;
   localparam reg_addr_t REG_FONT_PAGE = 4'd7;
   localparam reg_addr_t REG_SCAN      = 4'd8;
   localparam reg_addr_t REG_CTRL      = 4'd9;   // bit 0: start on write, busy on read

   typedef enum logic [1:0] {
      G_IDLE,
      G_CODE,
      G_FONT,
      G_HOLD
   } glyph_state_t;

   typedef enum logic [1:0] {
      A_IDLE,
      A_READ,
      A_HOLD
   } attr_state_t;

endpackage

`default_nettype wire

// ==== verilog/chroni_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroni_regs (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  chroni_pkg::reg_addr_t  wb_adr,
   input  chroni_pkg::byte_t      wb_dat_w,
   output chroni_pkg::byte_t      wb_dat_r,
   output logic                   wb_ack,
   output logic                   vram_we,
   output chroni_pkg::vram_addr_t vram_waddr,
   output chroni_pkg::byte_t      vram_wdata,
   output chroni_pkg::vram_addr_t text_base,
   output chroni_pkg::vram_addr_t attr_base,
   output chroni_pkg::byte_t      font_page,
   output chroni_pkg::scan_t      scan,
   output logic                   start,
   input  logic                   line_done
);
   import chroni_pkg::*;

   vram_addr_t data_addr;   // data port pointer
   logic       busy;
   logic       access;
   byte_t      rd_mux;

   assign access = wb_cyc & wb_stb & ~wb_ack;   // first cycle of a transfer

   always_comb begin
      case (wb_adr)
         REG_ADDR_LO:   rd_mux = data_addr[7:0];
         REG_ADDR_HI:   rd_mux = {2'b00, data_addr[13:8]};
         REG_TEXT_LO:   rd_mux = text_base[7:0];
         REG_TEXT_HI:   rd_mux = {2'b00, text_base[13:8]};
         REG_ATTR_LO:   rd_mux = attr_base[7:0];
         REG_ATTR_HI:   rd_mux = {2'b00, attr_base[13:8]};
         REG_FONT_PAGE: rd_mux = font_page;
         REG_SCAN:      rd_mux = {5'b00000, scan};
         REG_CTRL:      rd_mux = {7'b0000000, busy};
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         wb_ack    <= 1'b0;
         vram_we   <= 1'b0;
         start     <= 1'b0;
         busy      <= 1'b0;
         data_addr <= '0;
         text_base <= '0;
         attr_base <= '0;
         font_page <= '0;
         scan      <= '0;
      end else begin
         wb_ack  <= access;
         vram_we <= 1'b0;
         start   <= 1'b0;
         if (start)
            busy <= 1'b1;
         else if (line_done)
            busy <= 1'b0;
         if (access && wb_we) begin
            case (wb_adr)
               REG_ADDR_LO:   data_addr[7:0]  <= wb_dat_w;
               REG_ADDR_HI:   data_addr[13:8] <= wb_dat_w[5:0];
               REG_DATA: begin
                  vram_we   <= 1'b1;
                  data_addr <= data_addr + 1'b1;   // wraps at 16 KiB
               end
               REG_TEXT_LO:   text_base[7:0]  <= wb_dat_w;
               REG_TEXT_HI:   text_base[13:8] <= wb_dat_w[5:0];
               REG_ATTR_LO:   attr_base[7:0]  <= wb_dat_w;
               REG_ATTR_HI:   attr_base[13:8] <= wb_dat_w[5:0];
               REG_FONT_PAGE: font_page       <= wb_dat_w;
               REG_SCAN:      scan            <= wb_dat_w[2:0];
               REG_CTRL:      start           <= wb_dat_w[0] & ~busy;   // ignored while busy
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (access)
         wb_dat_r <= rd_mux;
      if (access && wb_we && wb_adr == REG_DATA) begin
         vram_waddr <= data_addr;
         vram_wdata <= wb_dat_w;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/chroni_text.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroni_text (
   input  logic                  sys_clk,
   input  logic                  rst,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  chroni_pkg::reg_addr_t wb_adr,
   input  chroni_pkg::byte_t     wb_dat_w,
   output chroni_pkg::byte_t     wb_dat_r,
   output logic                  wb_ack,
   output chroni_pkg::color_t    pixel,
   output logic                  pixel_valid,
   input  logic                  pixel_ready
);
   import chroni_pkg::*;

   logic       vram_we;
   vram_addr_t vram_waddr;
   byte_t      vram_wdata;
   vram_addr_t text_base;
   vram_addr_t attr_base;
   byte_t      font_page;
   scan_t      scan;
   logic       start;
   logic       line_done;
   vram_addr_t rd0_addr;
   byte_t      rd0_data;
   vram_addr_t rd1_addr;
   byte_t      rd1_data;
   byte_t      glyph_byte;
   logic       glyph_valid;
   byte_t      attr_byte;
   logic       attr_valid;
   logic       take;
   logic       shifter_empty;

   chroni_regs u_regs (
      .sys_clk    (sys_clk),
      .rst        (rst),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .vram_we    (vram_we),
      .vram_waddr (vram_waddr),
      .vram_wdata (vram_wdata),
      .text_base  (text_base),
      .attr_base  (attr_base),
      .font_page  (font_page),
      .scan       (scan),
      .start      (start),
      .line_done  (line_done)
   );

   vram u_vram (
      .sys_clk  (sys_clk),
      .we       (vram_we),
      .waddr    (vram_waddr),
      .wdata    (vram_wdata),
      .rd0_addr (rd0_addr),
      .rd0_data (rd0_data),
      .rd1_addr (rd1_addr),
      .rd1_data (rd1_data)
   );

   // port 0 serves char codes and font bytes
   glyph_fetch u_glyph (
      .sys_clk       (sys_clk),
      .rst           (rst),
      .start         (start),
      .text_base     (text_base),
      .font_page     (font_page),
      .scan          (scan),
      .rd0_addr      (rd0_addr),
      .rd0_data      (rd0_data),
      .glyph_byte    (glyph_byte),
      .glyph_valid   (glyph_valid),
      .take          (take),
      .shifter_empty (shifter_empty),
      .line_done     (line_done)
   );

   attr_fetch u_attr (
      .sys_clk    (sys_clk),
      .rst        (rst),
      .start      (start),
      .attr_base  (attr_base),
      .rd1_addr   (rd1_addr),
      .rd1_data   (rd1_data),
      .attr_byte  (attr_byte),
      .attr_valid (attr_valid),
      .take       (take)
   );

   pixel_shifter u_shifter (
      .sys_clk       (sys_clk),
      .rst           (rst),
      .glyph_byte    (glyph_byte),
      .glyph_valid   (glyph_valid),
      .attr_byte     (attr_byte),
      .attr_valid    (attr_valid),
      .take          (take),
      .shifter_empty (shifter_empty),
      .pixel         (pixel),
      .pixel_valid   (pixel_valid),
      .pixel_ready   (pixel_ready)
   );

endmodule

`default_nettype wire

// ==== verilog/glyph_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module glyph_fetch (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   start,
   input  chroni_pkg::vram_addr_t text_base,
   input  chroni_pkg::byte_t      font_page,
   input  chroni_pkg::scan_t      scan,
   output chroni_pkg::vram_addr_t rd0_addr,
   input  chroni_pkg::byte_t      rd0_data,
   output chroni_pkg::byte_t      glyph_byte,
   output logic                   glyph_valid,
   input  logic                   take,
   input  logic                   shifter_empty,
   output logic                   line_done
);
   import chroni_pkg::*;

   glyph_state_t state;
   col_t         col;
   byte_t        code_q;     // char code kept for the hold re-read
   byte_t        code;
   vram_addr_t   font_base;
   vram_addr_t   text_addr;
   vram_addr_t   font_addr;
   logic         draining;   // last column taken, shifter still busy

   assign font_base = vram_addr_t'({font_page, 8'h00});   // modulo memory size
   assign code      = (state == G_FONT) ? rd0_data : code_q;
   assign text_addr = text_base + vram_addr_t'(col);
   assign font_addr = font_base + vram_addr_t'(code) * vram_addr_t'(GLYPH_BYTES)
                      + vram_addr_t'(scan);

   // font address stays put during hold so the read port keeps the byte
   assign rd0_addr    = (state == G_FONT || state == G_HOLD) ? font_addr : text_addr;
   assign glyph_byte  = rd0_data;
   assign glyph_valid = (state == G_HOLD);
   assign line_done   = draining & shifter_empty;

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         state    <= G_IDLE;
         col      <= '0;
         draining <= 1'b0;
      end else begin
         if (line_done)
            draining <= 1'b0;
         case (state)
            G_IDLE: if (start) begin
               col   <= '0;
               state <= G_CODE;
            end
            G_CODE: state <= G_FONT;
            G_FONT: state <= G_HOLD;
            G_HOLD: if (take) begin
               if (col == col_t'(LINE_COLS - 1)) begin
                  state    <= G_IDLE;
                  draining <= 1'b1;
               end else begin
                  col   <= col + 1'b1;
                  state <= G_CODE;
               end
            end
            default: state <= G_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == G_FONT)
         code_q <= rd0_data;
   end

endmodule

`default_nettype wire

// ==== verilog/pixel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter (
   input  logic              sys_clk,
   input  logic              rst,
   input  chroni_pkg::byte_t glyph_byte,
   input  logic              glyph_valid,
   input  chroni_pkg::byte_t attr_byte,
   input  logic              attr_valid,
   output logic              take,
   output logic              shifter_empty,
   output chroni_pkg::color_t pixel,
   output logic              pixel_valid,
   input  logic              pixel_ready
);
   import chroni_pkg::*;

   byte_t      font_sr;
   color_t     fg;
   color_t     bg;
   logic [3:0] bits_left;
   logic       shift;

   assign shifter_empty = (bits_left == 4'd0);
   assign take          = glyph_valid & attr_valid & shifter_empty;
   assign pixel_valid   = ~shifter_empty;
   assign shift         = pixel_valid & pixel_ready;
   assign pixel         = font_sr[7] ? fg : bg;   // msb first

   always_ff @(posedge sys_clk) begin
      if (rst)
         bits_left <= 4'd0;
      else if (take)
         bits_left <= 4'($bits(byte_t));
      else if (shift)
         bits_left <= bits_left - 1'b1;
   end

   // low nibble colours set bits, high nibble clear bits
   always_ff @(posedge sys_clk) begin
      if (take) begin
         font_sr <= glyph_byte;
         fg      <= attr_byte[3:0];
         bg      <= attr_byte[7:4];
      end else if (shift) begin
         font_sr <= {font_sr[6:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/vram.sv ====
`timescale 1ns/1ps
`default_nettype none

module vram (
   input  logic                   sys_clk,
   input  logic                   we,
   input  chroni_pkg::vram_addr_t waddr,
   input  chroni_pkg::byte_t      wdata,
   input  chroni_pkg::vram_addr_t rd0_addr,
   output chroni_pkg::byte_t      rd0_data,
   input  chroni_pkg::vram_addr_t rd1_addr,
   output chroni_pkg::byte_t      rd1_data
);
   import chroni_pkg::*;

   byte_t mem [0:(1 << $bits(vram_addr_t)) - 1];

   always_ff @(posedge sys_clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   // both read ports have one cycle of latency
   always_ff @(posedge sys_clk) begin
      rd0_data <= mem[rd0_addr];
      rd1_data <= mem[rd1_addr];
   end

endmodule

`default_nettype wire
